// ==== hw/trace_mon_config.svh ====
`ifndef TRACE_MON_CONFIG_SVH
`define TRACE_MON_CONFIG_SVH

// Cores in the compute tile, one trace port each
`define TM_NUM_CORES 2

// Entries in the merged event queue
`define TM_QUEUE_DEPTH 8

// Upper instruction byte of l.nop
`define TM_NOP_OPCODE 8'h15

// Configuration port address width
`define TM_CFG_ADDR_W 3

`endif

// ==== hw/trace_mon_pkg.sv ====
`include "trace_mon_config.svh"

package trace_mon_pkg;

   // Basic data word of the core
   typedef logic [31:0] word_t;

   // Core index and per-core bit mask
   typedef logic core_id_t;
   typedef logic [`TM_NUM_CORES-1:0] core_mask_t;

   // Register file index
   typedef logic [4:0] reg_idx_t;

   // Event kind, also the bit position in the kind filter
   typedef logic [1:0] ev_kind_t;
   localparam ev_kind_t KIND_EXIT   = 2'd0;
   localparam ev_kind_t KIND_REPORT = 2'd1;
   localparam ev_kind_t KIND_PUTC   = 2'd2;

   // One filter bit per kind
   typedef logic [2:0] kind_mask_t;

   // Simulator control immediates of l.nop
   typedef logic [15:0] nop_imm_t;
   localparam nop_imm_t NOP_EXIT   = 16'h0001;
   localparam nop_imm_t NOP_REPORT = 16'h0002;
   localparam nop_imm_t NOP_PUTC   = 16'h0004;

   // Retired instruction as seen at write-back
   typedef struct packed {
      logic     valid;
      word_t    pc;
      word_t    insn;
      logic     wben;
      reg_idx_t wbreg;
      word_t    wbdata;
   } exec_trace_t;

   // Decoded event handed to the host
   typedef struct packed {
      core_id_t core;
      ev_kind_t kind;
      word_t    arg;
   } trace_event_t;

   // Host handshake FSM
   typedef enum logic [1:0] {
      Q_IDLE,
      Q_REQ,
      Q_WAIT_LOW
   } q_state_t;

endpackage

// ==== hw/trace_r3_shadow.sv ====
module trace_r3_shadow (
   input  logic                        clk_i,
   input  logic                        rst_n_i,

   // Trace record of one core
   input  trace_mon_pkg::exec_trace_t  trace_i,

   // Current value of r3
   output trace_mon_pkg::word_t        r3_o
);

   import trace_mon_pkg::*;

   // Argument register of the control no-ops
   localparam reg_idx_t R3_IDX = 5'd3;

   logic  r3_write;
   word_t r3_q;

   // Valid record with write-back to r3
   assign r3_write = trace_i.valid
                   & trace_i.wben
                   & (trace_i.wbreg == R3_IDX);

   // Shadow copy of the register
   // Updated at the edge that closes the write-back record,
   // so a no-op in the following cycle already sees the new value
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         r3_q <= '0;
      end else if (r3_write) begin
         r3_q <= trace_i.wbdata;
      end
   end

   assign r3_o = r3_q;

endmodule

// ==== hw/trace_sw_decoder.sv ====
`include "trace_mon_config.svh"

module trace_sw_decoder #(
   // Index of the core this decoder watches
   parameter int CORE_ID = 0
) (
   input  logic                         clk_i,
   input  logic                         rst_n_i,

   // Trace record and r3 shadow of the core
   input  trace_mon_pkg::exec_trace_t   trace_i,
   input  trace_mon_pkg::word_t         r3_i,

   // Steering from the register block
   input  logic                         core_en_i,
   input  trace_mon_pkg::kind_mask_t    kind_en_i,

   // Registered event, one cycle after the record
   output logic                         dec_valid_o,
   output trace_mon_pkg::trace_event_t  dec_ev_o
);

   import trace_mon_pkg::*;

   nop_imm_t     imm;
   logic         is_nop;
   logic         imm_known;
   ev_kind_t     kind_d;
   word_t        arg_d;
   logic         hit;
   logic         dec_valid_q;
   trace_event_t dec_ev_q;

   // l.nop carries its code in the low half
   assign imm    = trace_i.insn[15:0];
   assign is_nop = trace_i.valid
                 & (trace_i.insn[31:24] == `TM_NOP_OPCODE);

   // Immediate to kind and argument
   always_comb begin
      imm_known = 1'b1;
      kind_d    = KIND_EXIT;
      arg_d     = r3_i;
      case (imm)
         NOP_EXIT: begin
            kind_d = KIND_EXIT;
         end
         NOP_REPORT: begin
            kind_d = KIND_REPORT;
         end
         NOP_PUTC: begin
            kind_d = KIND_PUTC;
            // Character only, upper bytes cleared
            arg_d  = word_t'(r3_i[7:0]);
         end
         default: begin
            // Plain l.nop or unknown code
            imm_known = 1'b0;
         end
      endcase
   end

   // Core enable and kind filter gate the event
   assign hit = is_nop & imm_known & core_en_i & kind_en_i[kind_d];

   // Single-cycle valid
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         dec_valid_q <= 1'b0;
      end else begin
         dec_valid_q <= hit;
      end
   end

   // Payload only meaningful with valid
   always_ff @(posedge clk_i) begin
      if (hit) begin
         dec_ev_q.core <= core_id_t'(CORE_ID);
         dec_ev_q.kind <= kind_d;
         dec_ev_q.arg  <= arg_d;
      end
   end

   assign dec_valid_o = dec_valid_q;
   assign dec_ev_o    = dec_ev_q;

endmodule

// ==== hw/trace_mon_regs.sv ====
`include "trace_mon_config.svh"

module trace_mon_regs (
   input  logic                                             clk_i,
   input  logic                                             rst_n_i,

   // Configuration port, combinational read
   input  logic                                             cfg_we_i,
   input  logic [`TM_CFG_ADDR_W-1:0]                        cfg_addr_i,
   input  trace_mon_pkg::word_t                             cfg_wdata_i,
   output trace_mon_pkg::word_t                             cfg_rdata_o,

   // Decoded events, exits are captured here
   input  trace_mon_pkg::core_mask_t                        dec_valid_i,
   input  trace_mon_pkg::trace_event_t [`TM_NUM_CORES-1:0]  dec_ev_i,

   // One bit per event rejected by the queue
   input  trace_mon_pkg::core_mask_t                        drop_i,

   // Steering and termination
   output trace_mon_pkg::core_mask_t                        core_en_o,
   output trace_mon_pkg::kind_mask_t                        kind_en_o,
   output logic                                             done_o
);

   import trace_mon_pkg::*;

   localparam int NC = `TM_NUM_CORES;
   localparam int WW = $bits(word_t);

   // Register map
   localparam logic [`TM_CFG_ADDR_W-1:0] ADDR_CORE_EN = 'd0;
   localparam logic [`TM_CFG_ADDR_W-1:0] ADDR_KIND_EN = 'd1;
   localparam logic [`TM_CFG_ADDR_W-1:0] ADDR_STATUS  = 'd2;
   localparam logic [`TM_CFG_ADDR_W-1:0] ADDR_DROPS   = 'd3;
   localparam logic [`TM_CFG_ADDR_W-1:0] ADDR_EXIT0   = 'd4;

   // Done flag position in the status word
   localparam int DONE_BIT = 8;

   core_mask_t           core_en_q;
   kind_mask_t           kind_en_q;
   core_mask_t           exited_q;
   word_t [NC-1:0]       exit_code_q;
   word_t                drop_cnt_q;
   logic                 status_wr;
   logic [WW:0]          drop_sum;
   word_t                drop_next;
   logic                 done;
   word_t                status;

   assign status_wr = cfg_we_i & (cfg_addr_i == ADDR_STATUS);

   // Saturating add of this cycle's drops
   assign drop_sum  = {1'b0, drop_cnt_q} + (WW + 1)'($countones(drop_i));
   assign drop_next = drop_sum[WW] ? '1 : drop_sum[WW-1:0];

   // Masks, reset to all enabled
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         core_en_q <= '1;
         kind_en_q <= '1;
      end else if (cfg_we_i) begin
         if (cfg_addr_i == ADDR_CORE_EN) begin
            core_en_q <= cfg_wdata_i[NC-1:0];
         end
         if (cfg_addr_i == ADDR_KIND_EN) begin
            kind_en_q <= cfg_wdata_i[$bits(kind_mask_t)-1:0];
         end
      end
   end

   // Exit flags and codes
   // A status write clears the flags, an exit in the same cycle still sets
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         exited_q    <= '0;
         exit_code_q <= '0;
      end else begin
         if (status_wr) begin
            exited_q <= '0;
         end
         for (int c = 0; c < NC; c++) begin
            if (dec_valid_i[c] && (dec_ev_i[c].kind == KIND_EXIT)) begin
               exited_q[c]    <= 1'b1;
               exit_code_q[c] <= dec_ev_i[c].arg;
            end
         end
      end
   end

   // Drop counter
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         drop_cnt_q <= '0;
      end else if (status_wr) begin
         drop_cnt_q <= '0;
      end else if (|drop_i) begin
         drop_cnt_q <= drop_next;
      end
   end

   // All enabled cores exited, and at least one enabled
   assign done = (|core_en_q) && ((exited_q & core_en_q) == core_en_q);

   always_comb begin
      status           = '0;
      status[NC-1:0]   = exited_q;
      status[DONE_BIT] = done;
   end

   // Read mux
   always_comb begin
      cfg_rdata_o = '0;
      case (cfg_addr_i)
         ADDR_CORE_EN: cfg_rdata_o = word_t'(core_en_q);
         ADDR_KIND_EN: cfg_rdata_o = word_t'(kind_en_q);
         ADDR_STATUS:  cfg_rdata_o = status;
         ADDR_DROPS:   cfg_rdata_o = drop_cnt_q;
         default: begin
            // Exit codes from ADDR_EXIT0 up, one per core
            for (int c = 0; c < NC; c++) begin
               if (cfg_addr_i == ADDR_EXIT0 + c) begin
                  cfg_rdata_o = exit_code_q[c];
               end
            end
         end
      endcase
   end

   assign core_en_o = core_en_q;
   assign kind_en_o = kind_en_q;
   assign done_o    = done;

endmodule

// ==== hw/trace_event_queue.sv ====
`include "trace_mon_config.svh"

module trace_event_queue (
   input  logic                                             clk_i,
   input  logic                                             rst_n_i,

   // Events from all decoders
   input  trace_mon_pkg::core_mask_t                        dec_valid_i,
   input  trace_mon_pkg::trace_event_t [`TM_NUM_CORES-1:0]  dec_ev_i,

   // Rejected lanes, one pulse per lost event
   output trace_mon_pkg::core_mask_t                        drop_o,

   // Four-phase host port
   output trace_mon_pkg::trace_event_t                      ev_o,
   output logic                                             ev_req_o,
   input  logic                                             ev_ack_i
);

   import trace_mon_pkg::*;

   localparam int NC    = `TM_NUM_CORES;
   localparam int DEPTH = `TM_QUEUE_DEPTH;
   localparam int PTR_W = $clog2(DEPTH);
   localparam int CNT_W = $clog2(DEPTH + 1);

   typedef logic [PTR_W-1:0] ptr_t;
   typedef logic [CNT_W-1:0] cnt_t;

   trace_event_t      mem [DEPTH];
   ptr_t              wr_ptr_q;
   ptr_t              rd_ptr_q;
   cnt_t              count_q;
   core_mask_t        accept;
   ptr_t [NC-1:0]     slot;
   cnt_t              push_cnt;
   logic              pop;
   q_state_t          state_q;
   trace_event_t      ev_q;

   // Pointer advance with wrap, depth need not be a power of two
   function automatic ptr_t ptr_add(ptr_t p, int unsigned k);
      int unsigned sum;
      sum = int'(p) + k;
      if (sum >= DEPTH) begin
         sum = sum - DEPTH;
      end
      return ptr_t'(sum);
   endfunction

   // Lane 0 first, so core 0 lands ahead of core 1
   // A pop in the same cycle does not free room for a push
   always_comb begin
      int unsigned n;
      n        = 0;
      accept   = '0;
      slot     = '0;
      for (int c = 0; c < NC; c++) begin
         if (dec_valid_i[c] && ((int'(count_q) + n) < DEPTH)) begin
            accept[c] = 1'b1;
            slot[c]   = ptr_add(wr_ptr_q, n);
            n         = n + 1;
         end
      end
      push_cnt = cnt_t'(n);
   end

   assign drop_o = dec_valid_i & ~accept;

   // Head leaves on the rising ack
   assign pop = (state_q == Q_REQ) & ev_ack_i;

   // Storage
   always_ff @(posedge clk_i) begin
      for (int c = 0; c < NC; c++) begin
         if (accept[c]) begin
            mem[slot[c]] <= dec_ev_i[c];
         end
      end
   end

   // Pointers and fill level
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         wr_ptr_q <= ptr_add(wr_ptr_q, int'(push_cnt));
         if (pop) begin
            rd_ptr_q <= ptr_add(rd_ptr_q, 1);
         end
         count_q <= count_q + push_cnt - cnt_t'(pop);
      end
   end

   // Handshake FSM
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q <= Q_IDLE;
      end else begin
         case (state_q)
            Q_IDLE: begin
               if (count_q != '0) begin
                  state_q <= Q_REQ;
               end
            end
            Q_REQ: begin
               if (ev_ack_i) begin
                  state_q <= Q_WAIT_LOW;
               end
            end
            Q_WAIT_LOW: begin
               // Host must release ack before the next req
               if (!ev_ack_i) begin
                  state_q <= Q_IDLE;
               end
            end
            default: state_q <= Q_IDLE;
         endcase
      end
   end

   // Head copy, held stable while req is up
   always_ff @(posedge clk_i) begin
      if ((state_q == Q_IDLE) && (count_q != '0)) begin
         ev_q <= mem[rd_ptr_q];
      end
   end

   assign ev_o     = ev_q;
   assign ev_req_o = (state_q == Q_REQ);

endmodule

// ==== hw/trace_mon_top.sv ====
`include "trace_mon_config.svh"

module trace_mon_top (
   input  logic                                            clk_i,
   input  logic                                            rst_n_i,

   // Execution trace, one record per core
   input  trace_mon_pkg::exec_trace_t [`TM_NUM_CORES-1:0]  trace_i,

   // Configuration port
   input  logic                                            cfg_we_i,
   input  logic [`TM_CFG_ADDR_W-1:0]                       cfg_addr_i,
   input  trace_mon_pkg::word_t                            cfg_wdata_i,
   output trace_mon_pkg::word_t                            cfg_rdata_o,

   // Host event port, four-phase
   output trace_mon_pkg::trace_event_t                     ev_o,
   output logic                                            ev_req_o,
   input  logic                                            ev_ack_i,

   // All enabled cores terminated
   output logic                                            done_o
);

   import trace_mon_pkg::*;

   word_t        [`TM_NUM_CORES-1:0] r3;
   trace_event_t [`TM_NUM_CORES-1:0] dec_ev;
   core_mask_t                       dec_valid;
   core_mask_t                       core_en;
   kind_mask_t                       kind_en;
   core_mask_t                       drop;

   // Per-core shadow and decoder
   for (genvar c = 0; c < `TM_NUM_CORES; c++) begin : g_core
      trace_r3_shadow u_r3_shadow (
         .clk_i       (clk_i),
         .rst_n_i     (rst_n_i),
         .trace_i     (trace_i[c]),
         .r3_o        (r3[c])
      );

      trace_sw_decoder #(
         .CORE_ID     (c)
      ) u_decoder (
         .clk_i       (clk_i),
         .rst_n_i     (rst_n_i),
         .trace_i     (trace_i[c]),
         .r3_i        (r3[c]),
         .core_en_i   (core_en[c]),
         .kind_en_i   (kind_en),
         .dec_valid_o (dec_valid[c]),
         .dec_ev_o    (dec_ev[c])
      );
   end

   // Steering, exit capture and drop count
   trace_mon_regs u_regs (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .cfg_we_i    (cfg_we_i),
      .cfg_addr_i  (cfg_addr_i),
      .cfg_wdata_i (cfg_wdata_i),
      .cfg_rdata_o (cfg_rdata_o),
      .dec_valid_i (dec_valid),
      .dec_ev_i    (dec_ev),
      .drop_i      (drop),
      .core_en_o   (core_en),
      .kind_en_o   (kind_en),
      .done_o      (done_o)
   );

   // Merge and host handshake
   trace_event_queue u_queue (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .dec_valid_i (dec_valid),
      .dec_ev_i    (dec_ev),
      .drop_o      (drop),
      .ev_o        (ev_o),
      .ev_req_o    (ev_req_o),
      .ev_ack_i    (ev_ack_i)
   );

endmodule

// ==== tb/tb_trace_mon.sv ====
`include "trace_mon_config.svh"

module tb_trace_mon;

   timeunit 1ns;
   timeprecision 100ps;

   import trace_mon_pkg::*;

   localparam int    NC            = `TM_NUM_CORES;
   localparam string TRACE_FILE    = "tb/trace_mon_trace.txt";
   // Status register and its done bit
   localparam int    ADDR_STATUS   = 2;
   localparam int    DONE_BIT      = 8;
   // Per-test limits for draining and for catching extra events
   localparam int    DRAIN_LIMIT   = 400;
   localparam int    SETTLE_CYCLES = 30;

   logic                      clk_i;
   logic                      rst_n_i;
   exec_trace_t [NC-1:0]      trace_i;
   logic                      cfg_we_i;
   logic [`TM_CFG_ADDR_W-1:0] cfg_addr_i;
   word_t                     cfg_wdata_i;
   word_t                     cfg_rdata_o;
   trace_event_t              ev_o;
   logic                      ev_req_o;
   logic                      ev_ack_i;
   logic                      done_o;

   // Events the host still has to see, oldest first
   trace_event_t              exp_q[$];
   // Records waiting to go out in the same cycle
   exec_trace_t [NC-1:0]      stage;
   logic [NC-1:0]             staged;
   logic                      slow_host;
   int                        cycle_count;
   int                        cycle_limit;
   int                        check_count;
   int                        error_count;
   int                        tests_run;
   int                        tests_failed;
   int                        test_err_base;

   trace_mon_top dut0 (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .trace_i     (trace_i),
      .cfg_we_i    (cfg_we_i),
      .cfg_addr_i  (cfg_addr_i),
      .cfg_wdata_i (cfg_wdata_i),
      .cfg_rdata_o (cfg_rdata_o),
      .ev_o        (ev_o),
      .ev_req_o    (ev_req_o),
      .ev_ack_i    (ev_ack_i),
      .done_o      (done_o)
   );

   // 20 ns clock
   initial begin
      clk_i = 1'b0;
      forever #10 clk_i = ~clk_i;
   end

   task automatic check_value(input logic [63:0] got, input logic [63:0] exp,
                              input string what);
      check_count++;
      if (got !== exp) begin
         error_count++;
         $display("Mismatch at %0d ns: %s, got %0h, expected %0h", $time, what, got, exp);
      end
   endtask

   // All inputs change together at the rising edge
   task automatic cycle_step(input exec_trace_t [NC-1:0] tr, input logic we,
                             input logic [`TM_CFG_ADDR_W-1:0] addr, input word_t data);
      @(posedge clk_i);
      trace_i     <= tr;
      cfg_we_i    <= we;
      cfg_addr_i  <= addr;
      cfg_wdata_i <= data;
   endtask

   task automatic idle_cycle();
      cycle_step('0, 1'b0, '0, '0);
   endtask

   // Staged records of both cores, one cycle
   task automatic flush_stage();
      if (staged != '0) begin
         cycle_step(stage, 1'b0, '0, '0);
         stage  = '0;
         staged = '0;
      end
   endtask

   // Read data is combinational, sampled mid-cycle
   task automatic read_check(input logic [`TM_CFG_ADDR_W-1:0] addr, input word_t exp);
      cycle_step('0, 1'b0, addr, '0);
      @(negedge clk_i);
      check_value(64'(cfg_rdata_o), 64'(exp), $sformatf("read of address %0d", addr));
      if (addr == ADDR_STATUS) begin
         check_value(64'(done_o), 64'(exp[DONE_BIT]), "done_o against status bit 8");
      end
   endtask

   task automatic field_count(input int code, input int want, input logic [7:0] tag);
      if (code != want) begin
         error_count++;
         $display("Trace record %c has %0d fields, %0d were expected", tag, code, want);
      end
   endtask

   // Wait for the host to drain, then allow time for extra events
   task automatic finish_test(input logic [8*32-1:0] name);
      int waited;
      int errs;
      waited = 0;
      while ((exp_q.size() != 0) && (waited < DRAIN_LIMIT)) begin
         idle_cycle();
         waited++;
      end
      if (exp_q.size() != 0) begin
         $display("Test %0s: %0d expected events never reached the host", name, exp_q.size());
         error_count += exp_q.size();
         exp_q.delete();
      end
      repeat (SETTLE_CYCLES) idle_cycle();
      errs = error_count - test_err_base;
      tests_run++;
      if (errs == 0) begin
         $display("Test %0s: passed", name);
      end else begin
         tests_failed++;
         $display("Test %0s: failed with %0d errors", name, errs);
      end
      test_err_base = error_count;
   endtask

   task automatic count_lines(output int n);
      int               fd;
      logic [8*256-1:0] text;
      n  = 0;
      fd = $fopen(TRACE_FILE, "r");
      if (fd != 0) begin
         while ($fgets(text, fd) != 0) begin
            n++;
         end
         $fclose(fd);
      end
   endtask

   // One record per line, tag character first
   task automatic run_trace(input int fd);
      logic [7:0]                tag;
      logic [8*256-1:0]          skip;
      logic [8*32-1:0]           name;
      logic [`TM_CFG_ADDR_W-1:0] addr;
      int                        code;
      int                        core;
      int                        kind;
      int                        cycles;
      int                        slow;
      int                        wben;
      int                        wbreg;
      word_t                     pc;
      word_t                     insn;
      word_t                     wbdata;
      word_t                     data;
      trace_event_t              ev;
      while ($fscanf(fd, " %c", tag) == 1) begin
         case (tag)
            "#": code = $fgets(skip, fd);
            "T": begin
               code = $fscanf(fd, "%d %h %h %d %h %h", core, pc, insn, wben, wbreg, wbdata);
               field_count(code, 6, tag);
               // Same core again means a new cycle
               if (staged[core]) begin
                  flush_stage();
               end
               stage[core].valid  = 1'b1;
               stage[core].pc     = pc;
               stage[core].insn   = insn;
               stage[core].wben   = (wben != 0);
               stage[core].wbreg  = reg_idx_t'(wbreg);
               stage[core].wbdata = wbdata;
               staged[core]       = 1'b1;
            end
            "W": begin
               code = $fscanf(fd, "%h %h", addr, data);
               field_count(code, 2, tag);
               flush_stage();
               cycle_step('0, 1'b1, addr, data);
            end
            "R": begin
               code = $fscanf(fd, "%h %h", addr, data);
               field_count(code, 2, tag);
               flush_stage();
               read_check(addr, data);
            end
            "E": begin
               code = $fscanf(fd, "%d %d %h", core, kind, data);
               field_count(code, 3, tag);
               ev.core = core_id_t'(core);
               ev.kind = ev_kind_t'(kind);
               ev.arg  = data;
               exp_q.push_back(ev);
            end
            "H": begin
               code = $fscanf(fd, "%d", slow);
               field_count(code, 1, tag);
               slow_host = (slow != 0);
            end
            "I": begin
               code = $fscanf(fd, "%d", cycles);
               field_count(code, 1, tag);
               flush_stage();
               repeat (cycles) idle_cycle();
            end
            "X": begin
               code = $fscanf(fd, "%s", name);
               field_count(code, 1, tag);
               flush_stage();
               finish_test(name);
            end
            default: begin
               error_count++;
               $display("Unknown record type %c in the trace file", tag);
               code = $fgets(skip, fd);
            end
         endcase
      end
      flush_stage();
      idle_cycle();
   endtask

   // Host side of the four-phase port
   initial begin
      int unsigned  delay;
      trace_event_t got;
      trace_event_t exp;
      void'($urandom(32'h859c_a560));
      wait (rst_n_i === 1'b1);
      forever begin
         @(posedge clk_i);
         if (ev_req_o) begin
            delay = slow_host ? (12 + ($urandom % 4)) : ($urandom % 4);
            repeat (delay) @(posedge clk_i);
            got = ev_o;
            ev_ack_i <= 1'b1;
            if (exp_q.size() == 0) begin
               error_count++;
               $display("Surplus event at %0d ns: core %0d kind %0d arg %h was not expected",
                        $time, got.core, got.kind, got.arg);
            end else begin
               exp = exp_q.pop_front();
               check_value(64'(got), 64'(exp),
                           $sformatf("host event core %0d kind %0d arg %h",
                                     exp.core, exp.kind, exp.arg));
            end
            // Release ack only once req is down
            while (ev_req_o) @(posedge clk_i);
            ev_ack_i <= 1'b0;
         end
      end
   end

   // Run limit
   initial begin
      wait (cycle_limit != 0);
      while (cycle_count < cycle_limit) begin
         @(posedge clk_i);
         cycle_count++;
      end
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("CHECKS FAILED");
      $finish;
   end

   initial begin
      int lines;
      int fd;
      trace_i     = '0;
      cfg_we_i    = 1'b0;
      cfg_addr_i  = '0;
      cfg_wdata_i = '0;
      ev_ack_i    = 1'b0;
      rst_n_i     = 1'b0;
      stage       = '0;
      staged      = '0;
      slow_host   = 1'b0;
      count_lines(lines);
      cycle_limit = 40 * lines + 500;
      repeat (5) @(posedge clk_i);
      rst_n_i <= 1'b1;
      @(negedge clk_i);
      check_value(64'(ev_req_o), 64'd0, "ev_req_o after reset");
      check_value(64'(done_o), 64'd0, "done_o after reset");
      fd = $fopen(TRACE_FILE, "r");
      if (fd == 0) begin
         error_count++;
         $display("Cannot open the trace file %s", TRACE_FILE);
      end else begin
         run_trace(fd);
         $fclose(fd);
      end
      $display("Tests run %0d, tests failed %0d, checks %0d, errors %0d",
               tests_run, tests_failed, check_count, error_count);
      if (error_count == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule

// ==== sources.f ====
+incdir+hw
hw/trace_mon_pkg.sv
hw/trace_r3_shadow.sv
hw/trace_sw_decoder.sv
hw/trace_mon_regs.sv
hw/trace_event_queue.sv
hw/trace_mon_top.sv
tb/tb_trace_mon.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the trace monitor testbench with Verilator and runs it.
# Exit status is 0 only when the log holds the pass line.

set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=tb_trace_mon
LOG_FILE=sim.log

verilator --binary --timing -Wno-fatal \
   -f sources.f \
   --top-module tb_trace_mon \
   -Mdir "${BUILD_DIR}" \
   -o "${SIM_BIN}"
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

"./${BUILD_DIR}/${SIM_BIN}" > "${LOG_FILE}" 2>&1
sim_status=$?
cat "${LOG_FILE}"
if [ ${sim_status} -ne 0 ]; then
   echo "Simulation exited with status ${sim_status}"
   exit 1
fi

if grep -q "^ALL CHECKS PASSED$" "${LOG_FILE}"; then
   exit 0
fi
echo "Pass line not found in ${LOG_FILE}"
exit 1

// ==== tb/trace_mon_trace.txt ====
# T core pc insn wben wbreg wbdata | W addr data | R addr expected | E core kind arg
# H slow(0/1) | I idle cycles | X test name ; T lines of different cores in a row share a cycle
R 0 00000003
R 1 00000007
R 2 00000000
R 3 00000000
R 4 00000000
R 5 00000000
X reset
# r3 written, then used by the very next no-op
T 0 00000100 9c600141 1 03 00000141
T 1 00000200 9c600252 1 03 00000252
T 0 00000104 15000004 0 00 00000000
T 1 00000204 15000002 0 00 00000000
E 0 2 00000041
E 1 1 00000252
T 0 00000108 9c60cdef 1 03 89abcdef
T 0 0000010c 15000004 0 00 00000000
E 0 2 000000ef
X r3_args
T 0 00000110 15000002 0 00 00000000
T 1 00000208 15000004 0 00 00000000
E 0 1 89abcdef
E 1 2 00000052
T 1 0000020c 15000002 0 00 00000000
E 1 1 00000252
# Write to r4, unknown code and plain l.nop give nothing
T 0 00000114 9c800004 1 04 deadbeef
T 0 00000118 15000008 0 00 00000000
T 0 0000011c 15000000 0 00 00000000
T 0 00000120 15000004 0 00 00000000
E 0 2 000000ef
X order
W 0 00000001
R 0 00000001
T 0 00000124 15000002 0 00 00000000
T 1 00000210 15000002 0 00 00000000
E 0 1 89abcdef
W 1 00000005
R 1 00000005
W 0 00000003
T 0 00000128 15000002 0 00 00000000
T 1 00000214 15000004 0 00 00000000
E 1 2 00000052
W 1 00000007
R 1 00000007
X filters
# Eleven events against a slow host, the last three are dropped
H 1
T 0 0000012c 15000002 0 00 00000000
T 1 00000218 15000002 0 00 00000000
T 0 00000130 15000004 0 00 00000000
T 1 0000021c 15000004 0 00 00000000
T 0 00000134 15000002 0 00 00000000
T 1 00000220 15000002 0 00 00000000
T 0 00000138 15000004 0 00 00000000
T 1 00000224 15000004 0 00 00000000
T 0 0000013c 15000002 0 00 00000000
T 1 00000228 15000002 0 00 00000000
T 0 00000140 15000004 0 00 00000000
E 0 1 89abcdef
E 1 1 00000252
E 0 2 000000ef
E 1 2 00000052
E 0 1 89abcdef
E 1 1 00000252
E 0 2 000000ef
E 1 2 00000052
I 2
R 3 00000003
X overflow
H 0
W 2 00000000
R 3 00000000
R 2 00000000
T 0 00000144 9c600007 1 03 00000007
T 0 00000148 15000001 0 00 00000000
E 0 0 00000007
I 3
R 4 00000007
R 2 00000001
T 1 0000022c 15000001 0 00 00000000
E 1 0 00000252
I 3
R 5 00000252
R 2 00000103
W 2 00000000
R 2 00000000
X exit_done
